//--- include/rv_pipe_config.svh
// rv_pipe core parameters

`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// data path and address width
`define XLEN 64

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif

//--- hw/rv_pipe_pkg.sv
// rv_pipe shared types

package rv_pipe_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011; // register alu
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // immediate alu
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // only ebreak used

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // store and branch share the split immediate layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } sb_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        i_fmt_t  i;
        sb_fmt_t sb;
        u_fmt_t  u;
        j_fmt_t  j;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B // lui result
    } alu_op_e;

endpackage

//--- hw/if_stage.sv
// instruction fetch stage

`include "rv_pipe_config.svh"

module if_stage import rv_pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              redirect_i,
    input  logic [`XLEN-1:0]  redirect_pc_i,
    input  logic              halt_i,
    output logic [`XLEN-1:0]  imem_addr_o,
    input  logic [31:0]       imem_data_i,
    output logic              fd_valid_o,
    output logic [`XLEN-1:0]  fd_pc_o,
    output inst_u             fd_inst_o
);

    logic [`XLEN-1:0] pc_q;
    logic             stop_q; // set once ebreak retires
    logic             fetch_en;

    assign imem_addr_o = pc_q;
    assign fetch_en    = !stop_q && !halt_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q       <= `RESET_PC;
            stop_q     <= 1'b0;
            fd_valid_o <= 1'b0;
        end else begin
            stop_q <= stop_q | halt_i;
            if (redirect_i) begin // redirect beats stall
                pc_q       <= redirect_pc_i;
                fd_valid_o <= 1'b0;
            end else if (!stall_i) begin
                if (fetch_en) begin
                    pc_q <= pc_q + `XLEN'd4;
                end
                fd_valid_o <= fetch_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!redirect_i && !stall_i) begin
            fd_pc_o   <= pc_q;
            fd_inst_o <= imem_data_i;
        end
    end

endmodule

//--- hw/id_stage.sv
// instruction decode stage

`include "rv_pipe_config.svh"

module id_stage import rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   fd_valid_i,
    input  logic [`XLEN-1:0]       fd_pc_i,
    input  inst_u                  fd_inst_i,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic                   flush_i,
    input  logic [`REG_ADDR_W-1:0] ex_rd_i,
    input  logic                   ex_wen_i,
    output logic                   stall_o,
    output logic                   de_valid_o,
    output logic [`XLEN-1:0]       de_pc_o,
    output alu_op_e                de_alu_op_o,
    output logic [`XLEN-1:0]       de_op_a_o,
    output logic [`XLEN-1:0]       de_op_b_o,
    output logic [`XLEN-1:0]       de_rs2_data_o,
    output logic [2:0]             de_br_type_o,
    output logic                   de_jump_o,
    output logic                   de_jalr_o,
    output logic                   de_link_o,
    output logic [`REG_ADDR_W-1:0] de_rd_o,
    output logic                   de_wen_o,
    output logic                   de_ebreak_o
);

    logic [6:0]       opc;
    logic             is_op, is_imm, is_lui, is_auipc;
    logic             is_br, is_jal, is_jalr, is_ebreak;
    logic             use_rs1, use_rs2;
    logic             rs1_hit, rs2_hit;
    logic [`XLEN-1:0] imm;
    alu_op_e          alu_op;

    assign opc       = fd_inst_i.r.opcode;
    assign is_op     = (opc == OPC_OP);
    assign is_imm    = (opc == OPC_OP_IMM);
    assign is_lui    = (opc == OPC_LUI);
    assign is_auipc  = (opc == OPC_AUIPC);
    assign is_br     = (opc == OPC_BRANCH);
    assign is_jal    = (opc == OPC_JAL);
    assign is_jalr   = (opc == OPC_JALR);
    assign is_ebreak = (opc == OPC_SYSTEM) && (fd_inst_i.i.imm == 12'h001);

    assign rs1_addr_o = fd_inst_i.r.rs1;
    assign rs2_addr_o = fd_inst_i.r.rs2;
    assign use_rs1    = is_op || is_imm || is_br || is_jalr;
    assign use_rs2    = is_op || is_br;

    // raw check against both later stages, x0 never conflicts
    assign rs1_hit = use_rs1 && (rs1_addr_o != '0) &&
                     ((de_valid_o && de_wen_o && de_rd_o == rs1_addr_o) ||
                      (ex_wen_i && ex_rd_i == rs1_addr_o));
    assign rs2_hit = use_rs2 && (rs2_addr_o != '0) &&
                     ((de_valid_o && de_wen_o && de_rd_o == rs2_addr_o) ||
                      (ex_wen_i && ex_rd_i == rs2_addr_o));
    assign stall_o = fd_valid_i && (rs1_hit || rs2_hit);

    always_comb begin
        imm = '0;
        case (opc)
            OPC_OP_IMM, OPC_JALR:
                imm = {{(`XLEN-12){fd_inst_i.i.imm[11]}}, fd_inst_i.i.imm};
            OPC_BRANCH:
                imm = {{(`XLEN-12){fd_inst_i.sb.imm_hi[6]}}, fd_inst_i.sb.imm_lo[0],
                       fd_inst_i.sb.imm_hi[5:0], fd_inst_i.sb.imm_lo[4:1], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {{(`XLEN-32){fd_inst_i.u.imm[19]}}, fd_inst_i.u.imm, 12'b0};
            OPC_JAL:
                imm = {{(`XLEN-20){fd_inst_i.j.imm20}}, fd_inst_i.j.imm19_12,
                       fd_inst_i.j.imm11, fd_inst_i.j.imm10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD; // auipc, jalr target, branches
        if (is_lui) begin
            alu_op = ALU_PASS_B;
        end else if (is_op || is_imm) begin
            case (fd_inst_i.r.funct3)
                3'b000:  alu_op = (is_op && fd_inst_i.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_valid_o <= 1'b0;
        end else begin
            de_valid_o <= fd_valid_i && !stall_o && !flush_i; // bubble on stall
        end
    end

    // payload, only meaningful with de_valid_o
    always_ff @(posedge clk) begin
        de_pc_o       <= fd_pc_i;
        de_alu_op_o   <= alu_op;
        de_op_a_o     <= is_auipc ? fd_pc_i : rs1_data_i;
        de_op_b_o     <= is_op ? rs2_data_i : imm;
        de_rs2_data_o <= rs2_data_i;
        de_br_type_o  <= {is_br, fd_inst_i.sb.funct3[2], fd_inst_i.sb.funct3[0]};
        de_jump_o     <= is_jal || is_jalr;
        de_jalr_o     <= is_jalr;
        de_link_o     <= is_jal || is_jalr;
        de_rd_o       <= fd_inst_i.r.rd;
        de_wen_o      <= is_op || is_imm || is_lui || is_auipc || is_jal || is_jalr;
        de_ebreak_o   <= is_ebreak;
    end

endmodule

//--- hw/reg_file.sv
// integer register file

`include "rv_pipe_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    input  logic                   wen_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, same-cycle write is passed through
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (wen_i && waddr_i == rs1_addr_i) ? wdata_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (wen_i && waddr_i == rs2_addr_i) ? wdata_i : regs[rs2_addr_i];

endmodule

//--- hw/ex_stage.sv
// execute stage

`include "rv_pipe_config.svh"

module ex_stage import rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   de_valid_i,
    input  logic [`XLEN-1:0]       de_pc_i,
    input  alu_op_e                de_alu_op_i,
    input  logic [`XLEN-1:0]       de_op_a_i,
    input  logic [`XLEN-1:0]       de_op_b_i,
    input  logic [`XLEN-1:0]       de_rs2_data_i,
    input  logic [2:0]             de_br_type_i,
    input  logic                   de_jump_i,
    input  logic                   de_jalr_i,
    input  logic                   de_link_i,
    input  logic [`REG_ADDR_W-1:0] de_rd_i,
    input  logic                   de_wen_i,
    input  logic                   de_ebreak_i,
    output logic                   redirect_o,
    output logic [`XLEN-1:0]       redirect_pc_o,
    output logic                   wb_valid_o,
    output logic [`XLEN-1:0]       wb_pc_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_o,
    output logic                   wb_wen_o,
    output logic [`XLEN-1:0]       wb_data_o,
    output logic                   wb_ebreak_o,
    output logic                   halted_o
);

    logic [`XLEN-1:0] alu_res;
    logic             br_eq, br_lt, br_taken;
    logic             go; // valid and not past an ebreak

    always_comb begin
        case (de_alu_op_i)
            ALU_ADD:    alu_res = de_op_a_i + de_op_b_i;
            ALU_SUB:    alu_res = de_op_a_i - de_op_b_i;
            ALU_AND:    alu_res = de_op_a_i & de_op_b_i;
            ALU_OR:     alu_res = de_op_a_i | de_op_b_i;
            ALU_XOR:    alu_res = de_op_a_i ^ de_op_b_i;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(de_op_a_i) < $signed(de_op_b_i)};
            ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, de_op_a_i < de_op_b_i};
            ALU_PASS_B: alu_res = de_op_b_i;
            default:    alu_res = de_op_a_i + de_op_b_i;
        endcase
    end

    // br_type is {branch, less-than, invert}
    assign br_eq    = (de_op_a_i == de_rs2_data_i);
    assign br_lt    = ($signed(de_op_a_i) < $signed(de_rs2_data_i));
    assign br_taken = de_br_type_i[2] && ((de_br_type_i[1] ? br_lt : br_eq) ^ de_br_type_i[0]);

    assign go            = de_valid_i && !halted_o;
    assign redirect_o    = go && (br_taken || de_jump_i);
    assign redirect_pc_o = de_jalr_i ? {alu_res[`XLEN-1:1], 1'b0} : de_pc_i + de_op_b_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o  <= 1'b0;
            wb_wen_o    <= 1'b0;
            wb_ebreak_o <= 1'b0;
            halted_o    <= 1'b0;
        end else begin
            wb_valid_o  <= go;
            wb_wen_o    <= go && de_wen_i;
            wb_ebreak_o <= go && de_ebreak_i;
            halted_o    <= halted_o || (go && de_ebreak_i); // sticky
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_o   <= de_pc_i;
        wb_rd_o   <= de_rd_i;
        wb_data_o <= de_link_i ? de_pc_i + `XLEN'd4 : alu_res; // link gets pc+4
    end

endmodule

//--- hw/rv_pipe_top.sv
// rv_pipe four stage core

`include "rv_pipe_config.svh"

module rv_pipe_top import rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    output logic [`XLEN-1:0]       imem_addr_o,
    input  logic [31:0]            imem_data_i,
    output logic                   retire_valid_o,
    output logic [`XLEN-1:0]       retire_pc_o,
    output logic [`REG_ADDR_W-1:0] retire_rd_o,
    output logic [`XLEN-1:0]       retire_data_o,
    output logic                   retire_wen_o,
    output logic                   halted_o
);

    logic                   stall;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   fd_valid;
    logic [`XLEN-1:0]       fd_pc;
    inst_u                  fd_inst;
    logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [`XLEN-1:0]       rs1_data, rs2_data;
    logic                   de_valid;
    logic [`XLEN-1:0]       de_pc;
    alu_op_e                de_alu_op;
    logic [`XLEN-1:0]       de_op_a, de_op_b, de_rs2_data;
    logic [2:0]             de_br_type;
    logic                   de_jump, de_jalr, de_link;
    logic [`REG_ADDR_W-1:0] de_rd;
    logic                   de_wen, de_ebreak;
    logic                   wb_valid;
    logic [`XLEN-1:0]       wb_pc, wb_data;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic                   wb_wen, wb_ebreak;

    assign retire_valid_o = wb_valid; // diff-style retire view
    assign retire_pc_o    = wb_pc;
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;
    assign retire_wen_o   = wb_wen;

    if_stage u_if_stage (
        .clk(clk), .rst_i(rst_i),
        .stall_i(stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .halt_i(wb_ebreak),
        .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .fd_valid_o(fd_valid), .fd_pc_o(fd_pc), .fd_inst_o(fd_inst)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_i(rst_i),
        .fd_valid_i(fd_valid), .fd_pc_i(fd_pc), .fd_inst_i(fd_inst),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .flush_i(redirect), .ex_rd_i(wb_rd), .ex_wen_i(wb_wen), .stall_o(stall),
        .de_valid_o(de_valid), .de_pc_o(de_pc), .de_alu_op_o(de_alu_op),
        .de_op_a_o(de_op_a), .de_op_b_o(de_op_b), .de_rs2_data_o(de_rs2_data),
        .de_br_type_o(de_br_type), .de_jump_o(de_jump), .de_jalr_o(de_jalr),
        .de_link_o(de_link), .de_rd_o(de_rd), .de_wen_o(de_wen), .de_ebreak_o(de_ebreak)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_i(rst_i),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wen_i(wb_wen), .waddr_i(wb_rd), .wdata_i(wb_data)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_i(rst_i),
        .de_valid_i(de_valid), .de_pc_i(de_pc), .de_alu_op_i(de_alu_op),
        .de_op_a_i(de_op_a), .de_op_b_i(de_op_b), .de_rs2_data_i(de_rs2_data),
        .de_br_type_i(de_br_type), .de_jump_i(de_jump), .de_jalr_i(de_jalr),
        .de_link_i(de_link), .de_rd_i(de_rd), .de_wen_i(de_wen), .de_ebreak_i(de_ebreak),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .wb_valid_o(wb_valid), .wb_pc_o(wb_pc), .wb_rd_o(wb_rd), .wb_wen_o(wb_wen),
        .wb_data_o(wb_data), .wb_ebreak_o(wb_ebreak), .halted_o(halted_o)
    );

endmodule

//--- testbench/tb_checker.sv
// retirement checker and reference model

`include "rv_pipe_config.svh"

module tb_checker import rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [31:0]            prog_i [64],
    input  logic                   retire_valid_i,
    input  logic [`XLEN-1:0]       retire_pc_i,
    input  logic [`REG_ADDR_W-1:0] retire_rd_i,
    input  logic [`XLEN-1:0]       retire_data_i,
    input  logic                   retire_wen_i,
    input  logic                   halted_i,
    output logic                   done_o,
    output int                     err_count_o,
    output int                     check_count_o
);

    logic [`XLEN-1:0]       regs [`REG_COUNT];
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       next_pc;
    logic [`XLEN-1:0]       exp_data;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic                   exp_wen;
    logic                   exp_ebreak;

    task automatic compare_value(input string name, input logic [`XLEN-1:0] exp_v,
                                 input logic [`XLEN-1:0] act_v);
        if (act_v !== exp_v) begin
            err_count_o++;
            $display("error %s at pc %0h: expected %0h, actual %0h", name, pc, exp_v, act_v);
        end
    endtask

    // one instruction of the ISA at the model pc
    task automatic step_model();
        logic [31:0]      w;
        logic [6:0]       opc;
        logic [2:0]       f3;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] c;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_b;
        logic [`XLEN-1:0] imm_u;
        logic [`XLEN-1:0] imm_j;
        logic             taken;
        w     = prog_i[pc[7:2]];
        opc   = w[6:0];
        f3    = w[14:12];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {{32{w[31]}}, w[31:12], 12'b0};
        imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        a     = regs[w[19:15]];
        c     = regs[w[24:20]];
        b     = (opc == OPC_OP) ? c : imm_i;
        taken = 1'b0;
        exp_rd     = w[11:7];
        exp_wen    = 1'b0;
        exp_data   = '0;
        exp_ebreak = 1'b0;
        next_pc    = pc + 64'd4;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                exp_wen = 1'b1;
                case (f3)
                    3'b000:  exp_data = (opc == OPC_OP && w[30]) ? a - b : a + b;
                    3'b010:  exp_data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    3'b011:  exp_data = (a < b) ? 64'd1 : 64'd0;
                    3'b100:  exp_data = a ^ b;
                    3'b110:  exp_data = a | b;
                    default: exp_data = a & b;
                endcase
            end
            OPC_LUI: begin
                exp_wen  = 1'b1;
                exp_data = imm_u;
            end
            OPC_AUIPC: begin
                exp_wen  = 1'b1;
                exp_data = pc + imm_u;
            end
            OPC_JAL: begin
                exp_wen  = 1'b1;
                exp_data = pc + 64'd4;
                next_pc  = pc + imm_j;
            end
            OPC_JALR: begin
                exp_wen  = 1'b1;
                exp_data = pc + 64'd4;
                next_pc  = (a + imm_i) & ~64'd1;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  taken = (a == c);
                    3'b001:  taken = (a != c);
                    3'b100:  taken = ($signed(a) < $signed(c));
                    default: taken = ($signed(a) >= $signed(c)); // bge
                endcase
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            default: exp_ebreak = 1'b1; // only ebreak is left
        endcase
    endtask

    always @(negedge clk) begin
        if (rst_i) begin
            pc            = `RESET_PC;
            regs          = '{default: '0};
            done_o        = 1'b0;
            err_count_o   = 0;
            check_count_o = 0;
        end else begin
            if (done_o && !halted_i) begin
                err_count_o++;
                $display("halted dropped after the ebreak retired");
            end
            if (retire_valid_i) begin
                if (done_o) begin
                    err_count_o++;
                    $display("instruction at pc %0h retired after the ebreak", retire_pc_i);
                end else begin
                    check_count_o++;
                    step_model();
                    compare_value("retire pc", pc, retire_pc_i);
                    compare_value("write enable", 64'(exp_wen), 64'(retire_wen_i));
                    if (exp_wen) begin
                        compare_value("rd", 64'(exp_rd), 64'(retire_rd_i));
                        compare_value("rd data", exp_data, retire_data_i);
                        if (exp_rd != '0) begin
                            regs[exp_rd] = exp_data; // x0 stays zero
                        end
                    end
                    compare_value("halted", 64'(exp_ebreak), 64'(halted_i));
                    done_o = exp_ebreak;
                    pc     = next_pc;
                end
            end
        end
    end

endmodule

//--- testbench/tb_top.sv
// rv_pipe testbench top

`include "rv_pipe_config.svh"

module tb_top import rv_pipe_pkg::*; ();

    localparam int          PROG_LEN       = 64;
    localparam int          TIMEOUT_CYCLES = PROG_LEN * 3 + 50;
    localparam logic [31:0] EBREAK_WORD    = 32'h0010_0073;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [`XLEN-1:0]       imem_addr;
    logic [31:0]            imem_data;
    logic                   retire_valid;
    logic [`XLEN-1:0]       retire_pc;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;
    logic                   retire_wen;
    logic                   halted;
    logic [31:0]            prog [PROG_LEN];
    logic                   done;
    logic                   timed_out;
    int                     err_count;
    int                     check_count;
    int                     cycle_cnt;

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    // fetches past the program see ebreak
    assign imem_data = (imem_addr < 64'd256) ? prog[imem_addr[7:2]] : EBREAK_WORD;

    rv_pipe_top i_dut (
        .clk(clk), .rst_i(rst),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .retire_valid_o(retire_valid), .retire_pc_o(retire_pc), .retire_rd_o(retire_rd),
        .retire_data_o(retire_data), .retire_wen_o(retire_wen), .halted_o(halted)
    );

    tb_checker u_checker (
        .clk(clk), .rst_i(rst), .prog_i(prog),
        .retire_valid_i(retire_valid), .retire_pc_i(retire_pc), .retire_rd_i(retire_rd),
        .retire_data_i(retire_data), .retire_wen_i(retire_wen), .halted_i(halted),
        .done_o(done), .err_count_o(err_count), .check_count_o(check_count)
    );

    function automatic logic [4:0] pick_reg();
        return 5'($urandom % 16); // small window for frequent dependencies
    endfunction

    // forward distance in words up to the last word
    function automatic int forward_words(int idx);
        int room;
        room = PROG_LEN - 1 - idx;
        if (room > 6) begin
            room = 6;
        end
        return 1 + int'($urandom % room);
    endfunction

    task automatic build_program();
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [12:0] boff;
        logic [20:0] joff;
        int          k;
        int          sel;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            rd   = pick_reg();
            rs1  = pick_reg();
            rs2  = pick_reg();
            k    = forward_words(i);
            boff = 13'(k * 4);
            joff = 21'(k * 4);
            case ($urandom % 12)
                0, 1, 2: begin
                    sel = int'($urandom % 7);
                    f7  = (sel == 1) ? 7'h20 : 7'h00; // sub
                    case (sel)
                        0, 1:    f3 = 3'b000;
                        2:       f3 = 3'b111;
                        3:       f3 = 3'b110;
                        4:       f3 = 3'b100;
                        5:       f3 = 3'b010;
                        default: f3 = 3'b011;
                    endcase
                    w = {f7, rs2, rs1, f3, rd, OPC_OP};
                end
                3, 4, 5: begin
                    case ($urandom % 5)
                        0:       f3 = 3'b000; // addi
                        1:       f3 = 3'b111;
                        2:       f3 = 3'b110;
                        3:       f3 = 3'b100;
                        default: f3 = 3'b010; // slti
                    endcase
                    w = {12'($urandom), rs1, f3, rd, OPC_OP_IMM};
                end
                6:       w = {20'($urandom), rd, OPC_LUI};
                7:       w = {20'($urandom), rd, OPC_AUIPC};
                8, 9: begin
                    case ($urandom % 4)
                        0:       f3 = 3'b000; // beq
                        1:       f3 = 3'b001;
                        2:       f3 = 3'b100;
                        default: f3 = 3'b101; // bge
                    endcase
                    w = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
                end
                10:      w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
                default: w = {12'((i + k) * 4), 5'd0, 3'b000, rd, OPC_JALR}; // absolute target
            endcase
            prog[6'(i)] = w;
        end
        prog[6'(PROG_LEN - 1)] = EBREAK_WORD;
    endtask

    initial begin
        void'($urandom(56364));
        rst       <= 1'b1;
        timed_out = 1'b0;
        build_program();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        while (!done && cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("timeout: ebreak did not retire within %0d cycles", TIMEOUT_CYCLES);
        end else begin
            repeat (10) @(posedge clk); // window for stray retirements after the halt
        end
        $display("retirements checked: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- rv_pipe.f
+incdir+include
hw/rv_pipe_pkg.sv
hw/if_stage.sv
hw/id_stage.sv
hw/reg_file.sv
hw/ex_stage.sv
hw/rv_pipe_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- build.sh
#!/usr/bin/env bash
# compile the rv_pipe testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -f rv_pipe.f -o tb_top_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_top_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
